//--- src/link_pkg.sv
package link_pkg;

    localparam int LANES     = 5;
    localparam int MAX_SLOTS = 10;  // data frame length

    typedef logic [LANES-1:0] slot_t;  // one bit-time across all lanes
    typedef logic [3:0]       slot_count_t;

    typedef enum logic [1:0] {
        KIND_COMMA_1,  // 2 slots
        KIND_COMMA_2,  // 4 slots
        KIND_DATA      // 10 slots
    } frame_kind_e;

    typedef struct packed {
        frame_kind_e                kind;
        slot_t [MAX_SLOTS-1:0]      slots;  // slot 0 goes out first
    } frame_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_RECEIVE, RX_ERROR} rx_state_e;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SLOTS, TX_STOP} tx_state_e;

    function automatic slot_count_t kind_slots(frame_kind_e kind);
        case (kind)
            KIND_COMMA_1: begin
                return slot_count_t'(2);
            end
            KIND_COMMA_2: begin
                return slot_count_t'(4);
            end
            default: begin
                return slot_count_t'(MAX_SLOTS);
            end
        endcase
    endfunction

endpackage

//--- src/bit_synchronizer.sv
module bit_synchronizer (
    input  logic CLK,
    input  logic nRST,
    input  logic async_in,
    output logic sync_out
);

    logic meta;  // first stage, may go metastable

    // lanes idle high, so both stages reset high
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            meta     <= 1'b1;
            sync_out <= 1'b1;
        end else begin
            meta     <= async_in;
            sync_out <= meta;
        end
    end

endmodule

//--- src/baud_timer.sv
module baud_timer #(
    parameter int CLKDIV_COUNT = 8
) (
    input  logic CLK,
    input  logic nRST,
    input  logic clear,
    input  logic enable,
    input  logic half,
    output logic tick
);

    localparam int CNT_W = $clog2(CLKDIV_COUNT + 1);
    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(CLKDIV_COUNT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKDIV_COUNT / 2 - 1);

    logic [CNT_W-1:0] count;
    logic             first_half;  // short first interval pending

    assign tick = enable && (count == (first_half ? HALF_LAST : FULL_LAST));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count      <= '0;
            first_half <= 1'b0;
        end else if (clear) begin
            count      <= '0;
            first_half <= half;
        end else if (tick) begin
            count      <= '0;  // wrap, later intervals are full periods
            first_half <= 1'b0;
        end else if (enable) begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- src/frame_rx.sv
module frame_rx #(
    parameter int CLKDIV_COUNT = 8
) (
    input  logic             CLK,
    input  logic             nRST,
    input  link_pkg::slot_t  lanes,
    output logic             done,
    output link_pkg::frame_t frame,
    output logic             err
);

    link_pkg::rx_state_e                      state;
    link_pkg::rx_state_e                      n_state;
    link_pkg::slot_t                          sync_lanes;
    link_pkg::slot_t [link_pkg::MAX_SLOTS-1:0] shift_reg;
    link_pkg::slot_count_t                    slot_cnt;
    link_pkg::frame_kind_e                    kind;
    logic all_low;
    logic all_high;
    logic tick;
    logic len_ok;
    logic shift_en;
    logic stop_ok;
    logic fault;

    genvar i;
    generate
        for (i = 0; i < link_pkg::LANES; i++) begin : g_sync
            bit_synchronizer u_sync (
                .CLK     (CLK),
                .nRST    (nRST),
                .async_in(lanes[i]),
                .sync_out(sync_lanes[i])
            );
        end
    endgenerate

    // held clear while waiting, first tick lands mid start bit
    baud_timer #(.CLKDIV_COUNT(CLKDIV_COUNT)) u_timer (
        .CLK   (CLK),
        .nRST  (nRST),
        .clear (state == link_pkg::RX_IDLE || state == link_pkg::RX_ERROR),
        .enable(state == link_pkg::RX_START || state == link_pkg::RX_RECEIVE),
        .half  (state == link_pkg::RX_IDLE),
        .tick  (tick)
    );

    assign all_low  = ~|sync_lanes;
    assign all_high = &sync_lanes;

    always_comb begin
        len_ok = 1'b1;
        case (slot_cnt)
            4'd2:    kind = link_pkg::KIND_COMMA_1;
            4'd4:    kind = link_pkg::KIND_COMMA_2;
            4'd10:   kind = link_pkg::KIND_DATA;
            default: begin
                kind   = link_pkg::KIND_DATA;
                len_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        n_state  = state;
        shift_en = 1'b0;
        stop_ok  = 1'b0;
        fault    = 1'b0;
        case (state)
            link_pkg::RX_IDLE: begin
                if (all_low) n_state = link_pkg::RX_START;
            end
            link_pkg::RX_START: begin
                if (tick && all_low) n_state = link_pkg::RX_RECEIVE;
                else if (tick) fault = 1'b1;  // start glitch
            end
            link_pkg::RX_RECEIVE: begin
                if (tick && all_high) begin
                    stop_ok = len_ok;
                    fault   = !len_ok;
                    n_state = link_pkg::RX_IDLE;
                end else if (tick) begin
                    if (all_low || slot_cnt == link_pkg::slot_count_t'(link_pkg::MAX_SLOTS))
                        fault = 1'b1;
                    else
                        shift_en = 1'b1;
                end
            end
            default: begin
                if (all_high) n_state = link_pkg::RX_IDLE;  // wait for idle lanes
            end
        endcase
        if (fault) n_state = link_pkg::RX_ERROR;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= link_pkg::RX_IDLE;
            slot_cnt <= '0;
            done     <= 1'b0;
            err      <= 1'b0;
        end else begin
            state <= n_state;
            done  <= stop_ok;
            err   <= fault;
            if (state == link_pkg::RX_IDLE) slot_cnt <= '0;
            else if (shift_en) slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // newest slot enters at the top, right-aligned at the stop
    always_ff @(posedge CLK) begin
        if (state == link_pkg::RX_IDLE)
            shift_reg <= '0;
        else if (shift_en)
            shift_reg <= {sync_lanes, shift_reg[link_pkg::MAX_SLOTS-1:1]};
        if (stop_ok) begin
            frame.kind  <= kind;
            frame.slots <= shift_reg >> (link_pkg::LANES * (link_pkg::MAX_SLOTS - slot_cnt));
        end
    end

endmodule

//--- src/frame_tx.sv
module frame_tx #(
    parameter int CLKDIV_COUNT = 8
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             send,
    input  link_pkg::frame_t frame,
    output logic             busy,
    output link_pkg::slot_t  lanes
);

    localparam int CNT_W = $clog2(CLKDIV_COUNT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKDIV_COUNT - 1);

    link_pkg::tx_state_e   state;
    link_pkg::frame_t      frame_q;
    link_pkg::slot_count_t slot_idx;
    link_pkg::slot_count_t slot_last;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  bit_end;

    assign bit_end   = (bit_cnt == BIT_LAST);
    assign slot_last = link_pkg::kind_slots(frame_q.kind) - 1'b1;
    assign busy      = (state != link_pkg::TX_IDLE);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= link_pkg::TX_IDLE;
            bit_cnt  <= '0;
            slot_idx <= '0;
        end else begin
            // bit period restarts on every state change
            if (state == link_pkg::TX_IDLE || bit_end) bit_cnt <= '0;
            else bit_cnt <= bit_cnt + 1'b1;

            case (state)
                link_pkg::TX_IDLE: begin
                    if (send) state <= link_pkg::TX_START;
                end
                link_pkg::TX_START: begin
                    if (bit_end) begin
                        state    <= link_pkg::TX_SLOTS;
                        slot_idx <= '0;
                    end
                end
                link_pkg::TX_SLOTS: begin
                    if (bit_end && slot_idx == slot_last) state <= link_pkg::TX_STOP;
                    else if (bit_end) slot_idx <= slot_idx + 1'b1;
                end
                default: begin
                    if (bit_end) state <= link_pkg::TX_IDLE;  // stop bit done
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == link_pkg::TX_IDLE && send) frame_q <= frame;
    end

    always_comb begin
        case (state)
            link_pkg::TX_START: lanes = '0;
            link_pkg::TX_SLOTS: lanes = frame_q.slots[slot_idx];
            default:            lanes = '1;  // stop and idle are high
        endcase
    end

endmodule

//--- src/link_top.sv
module link_top #(
    parameter int CLKDIV_COUNT = 8
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             tx_send,
    input  link_pkg::frame_t tx_frame,
    output logic             tx_busy,
    output link_pkg::slot_t  tx_lanes,
    input  link_pkg::slot_t  rx_lanes,
    output logic             rx_done,
    output link_pkg::frame_t rx_frame,
    output logic             rx_err
);

    // tx and rx share CLK but have separate pins
    frame_tx #(
        .CLKDIV_COUNT(CLKDIV_COUNT)
    ) tx (
        .CLK  (CLK),
        .nRST (nRST),
        .send (tx_send),
        .frame(tx_frame),
        .busy (tx_busy),
        .lanes(tx_lanes)
    );

    frame_rx #(
        .CLKDIV_COUNT(CLKDIV_COUNT)
    ) rx (
        .CLK  (CLK),
        .nRST (nRST),
        .lanes(rx_lanes),
        .done (rx_done),
        .frame(rx_frame),
        .err  (rx_err)
    );

endmodule

//--- verification/link_props.sv
module link_props (
    input logic            CLK,
    input logic            nRST,
    input logic            tx_send,
    input logic            tx_busy,
    input link_pkg::slot_t tx_lanes,
    input logic            rx_done,
    input logic            rx_err
);

    strobes_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(rx_done && rx_err)) else $error("rx_done and rx_err high together");

    idle_lanes_high: assert property (@(posedge CLK) disable iff (!nRST)
        !tx_busy |-> tx_lanes == '1) else $error("tx_lanes not all high while tx idle");

    done_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        rx_done |=> !rx_done) else $error("rx_done longer than one cycle");

    err_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        rx_err |=> !rx_err) else $error("rx_err longer than one cycle");

    // busy only starts from an accepted send
    busy_after_send: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(tx_busy) |-> $past(tx_send)) else $error("tx_busy rose without tx_send");

endmodule

bind link_top link_props props (
    .CLK     (CLK),
    .nRST    (nRST),
    .tx_send (tx_send),
    .tx_busy (tx_busy),
    .tx_lanes(tx_lanes),
    .rx_done (rx_done),
    .rx_err  (rx_err)
);

//--- verification/link_tb.sv
module link_tb;

    localparam int CLKDIV    = 8;
    localparam int BIT_LIMIT = 40 * CLKDIV;  // well over one data frame

    logic             CLK;
    logic             nRST;
    logic             tx_send;
    link_pkg::frame_t tx_frame;
    logic             tx_busy;
    link_pkg::slot_t  tx_lanes;
    link_pkg::slot_t  rx_lanes;
    logic             rx_done;
    link_pkg::frame_t rx_frame;
    logic             rx_err;

    logic             inj_en;
    link_pkg::slot_t  inj_val;
    link_pkg::frame_t exp_q[$];  // sent frames not yet received
    logic [31:0]      rng = 32'd98;
    int errors       = 0;
    int done_count   = 0;
    int err_count    = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int base_errors;
    int base_done;
    int base_rx_err;

    assign rx_lanes = inj_en ? inj_val : tx_lanes;  // corruption path

    link_top #(.CLKDIV_COUNT(CLKDIV)) uut (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int slots_for_kind(input link_pkg::frame_kind_e kind);
        case (kind)
            link_pkg::KIND_COMMA_1: return 2;
            link_pkg::KIND_COMMA_2: return 4;
            default:                return 10;
        endcase
    endfunction

    task automatic check(input bit ok, input string what);
        assert (ok) else begin
            $display("ERR %0t: %s", $time, what);
            errors++;
        end
    endtask

    // random slots, never all-zero or all-one
    task automatic build_frame(input link_pkg::frame_kind_e kind, output link_pkg::frame_t f);
        link_pkg::slot_t s;
        int i;
        f      = '0;
        f.kind = kind;
        for (i = 0; i < slots_for_kind(kind); i++) begin
            s = '0;
            while (s == '0 || s == '1) begin
                rng = xorshift32(rng);
                s   = rng[link_pkg::LANES-1:0];
            end
            f.slots[i] = s;
        end
    endtask

    task automatic watch_rx();
        link_pkg::frame_t exp_frame;
        forever begin
            @(negedge CLK);
            if (rx_err) err_count++;
            if (rx_done) begin
                done_count++;
                check(exp_q.size() > 0, "rx_done with no frame outstanding");
                if (exp_q.size() > 0) begin
                    exp_frame = exp_q.pop_front();
                    check(rx_frame == exp_frame,
                          $sformatf("rx_frame %h, expected %h", rx_frame, exp_frame));
                end
            end
        end
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (tx_busy !== level && n < limit);
        if (tx_busy !== level) begin
            $display("timeout: tx_busy did not go to %0b within %0d cycles", level, limit);
            errors++;
        end
    endtask

    task automatic wait_strobes(input int dones, input int errs, input int limit);
        int n;
        n = 0;
        while ((done_count < dones || err_count < errs) && n < limit) begin
            @(negedge CLK);
            n++;
        end
        if (done_count < dones || err_count < errs) begin
            $display("timeout: waited for %0d rx_done and %0d rx_err, saw %0d and %0d",
                     dones, errs, done_count, err_count);
            errors++;
        end
    endtask

    task automatic send_frame(input link_pkg::frame_t f, input bit expect_rx);
        @(posedge CLK);
        tx_send  <= 1'b1;
        tx_frame <= f;
        @(posedge CLK);
        tx_send <= 1'b0;
        if (expect_rx) exp_q.push_back(f);
        wait_busy(1'b1, 4);  // returns early in the start bit-time
    endtask

    task automatic inject(input link_pkg::slot_t v, input int after, input int cycles);
        repeat (after) @(posedge CLK);
        inj_en  <= 1'b1;
        inj_val <= v;
        repeat (cycles) @(posedge CLK);
        inj_en <= 1'b0;
    endtask

    task automatic loop_one(input link_pkg::frame_t f);
        int dones;
        int errs;
        dones = done_count;
        errs  = err_count;
        send_frame(f, 1'b1);
        wait_strobes(dones + 1, 0, BIT_LIMIT);
        wait_busy(1'b0, BIT_LIMIT);
        check(done_count == dones + 1 && err_count == errs, "clean frame not received once");
    endtask

    // one rx_err, no rx_done, then a clean frame must get through
    task automatic error_then_recover(input string what);
        link_pkg::frame_t f;
        wait_strobes(base_done, base_rx_err + 1, BIT_LIMIT);
        wait_busy(1'b0, BIT_LIMIT);
        check(done_count == base_done && err_count == base_rx_err + 1,
              {what, ": expected one rx_err and no rx_done"});
        build_frame(link_pkg::KIND_COMMA_2, f);
        loop_one(f);
    endtask

    task automatic start_test();
        base_errors = errors;
        base_done   = done_count;
        base_rx_err = err_count;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == base_errors) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail", name);
        end
    endtask

    initial begin
        link_pkg::frame_t f;
        link_pkg::frame_t g;
        int i;
        nRST     = 1'b0;
        tx_send  = 1'b0;
        tx_frame = '0;
        inj_en   = 1'b0;
        inj_val  = '1;
        fork
            watch_rx();
        join_none
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;

        start_test();
        repeat (50) begin
            @(negedge CLK);
            check(tx_lanes == '1 && !tx_busy, "transmitter not idle after reset");
            check(!rx_done && !rx_err, "receiver strobe after reset");
        end
        finish_test("reset_idle");

        start_test();
        build_frame(link_pkg::KIND_COMMA_1, f);
        loop_one(f);
        build_frame(link_pkg::KIND_COMMA_2, f);
        loop_one(f);
        build_frame(link_pkg::KIND_DATA, f);
        loop_one(f);
        finish_test("loopback_kinds");

        start_test();
        for (i = 0; i < 10; i++) begin
            rng = xorshift32(rng);
            case (rng % 3)
                0:       build_frame(link_pkg::KIND_COMMA_1, f);
                1:       build_frame(link_pkg::KIND_COMMA_2, f);
                default: build_frame(link_pkg::KIND_DATA, f);
            endcase
            send_frame(f, 1'b1);
            wait_busy(1'b0, BIT_LIMIT);
        end
        wait_strobes(base_done + 10, base_rx_err, BIT_LIMIT);
        check(done_count == base_done + 10 && err_count == base_rx_err,
              "back-to-back frames lost or errored");
        finish_test("back_to_back");

        start_test();
        build_frame(link_pkg::KIND_DATA, f);
        build_frame(link_pkg::KIND_COMMA_1, g);
        send_frame(f, 1'b1);
        repeat (2) @(posedge CLK);
        tx_send  <= 1'b1;  // lands mid start bit, must be dropped
        tx_frame <= g;
        @(posedge CLK);
        tx_send <= 1'b0;
        wait_strobes(base_done + 1, base_rx_err, BIT_LIMIT);
        wait_busy(1'b0, BIT_LIMIT);
        repeat (4 * CLKDIV) begin
            @(negedge CLK);
            check(!tx_busy, "dropped send restarted the transmitter");
        end
        check(done_count == base_done + 1 && err_count == base_rx_err,
              "send while busy was not dropped");
        finish_test("send_while_busy");

        start_test();
        build_frame(link_pkg::KIND_DATA, f);
        send_frame(f, 1'b0);
        inject('0, 3 * CLKDIV, 2 * CLKDIV);  // covers the sample of slot 2
        error_then_recover("low slot");
        finish_test("inject_low_slot");

        start_test();
        build_frame(link_pkg::KIND_DATA, f);
        send_frame(f, 1'b0);
        inject('1, 4 * CLKDIV, 8 * CLKDIV);  // early stop after 3 slots
        error_then_recover("bad length");
        finish_test("inject_bad_length");

        start_test();
        inject('0, 1, CLKDIV / 4);
        error_then_recover("start glitch");
        finish_test("inject_start_glitch");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- files.f
src/link_pkg.sv
src/bit_synchronizer.sv
src/baud_timer.sv
src/frame_rx.sv
src/frame_tx.sv
src/link_top.sv
verification/link_props.sv
verification/link_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= link_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
